// File: ising_cfg_pkg.sv
/*
 * spin system sizes, value types, result record
 * and controller state encoding
 */
package ising_cfg_pkg;

    localparam int NumSpin    = 16;
    localparam int BitJ       = 4;
    localparam int BitH       = 4;
    localparam int FieldBits  = 10;
    localparam int EnergyBits = 16;

    // bit i set means spin +1, clear means -1
    typedef logic [NumSpin-1:0] spin_vec_t;

    // element j of a row sits at bits 4j+3 down to 4j
    typedef logic [NumSpin*BitJ-1:0] j_row_t;
    typedef logic [NumSpin*BitH-1:0] h_vec_t;

    typedef logic signed [BitJ-1:0]       j_val_t;
    typedef logic signed [BitH-1:0]       h_val_t;
    typedef logic signed [FieldBits-1:0]  field_t;
    typedef logic signed [EnergyBits-1:0] energy_t;

    typedef logic [$clog2(NumSpin)-1:0] row_idx_t;
    typedef logic [7:0]                 iter_cnt_t;
    typedef logic [2:0]                 icon_cnt_t;

    // one entry per finished iteration
    typedef struct packed {
        spin_vec_t spin;
        energy_t   energy;
    } result_t;

    typedef enum logic [2:0] {
        StIdle,
        StIcon,
        StRows,
        StDrain,
        StCommit
    } ctrl_state_e;

endpackage

// File: ising_bus_pkg.sv
/*
 * host bus structs, local memory ports
 * and register address map
 */
package ising_bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  word_addr_t;

    // single-cycle strobe, always accepted
    typedef struct packed {
        logic       valid;
        logic       write;
        word_addr_t addr;
        word_t      wdata;
    } host_req_t;

    typedef struct packed {
        logic  rvalid;
        word_t rdata;
    } host_rsp_t;

    // host side write, word addressed within the memory
    typedef struct packed {
        logic       en;
        word_addr_t addr;
        word_t      data;
    } mem_wr_t;

    // core side read, row addressed
    typedef struct packed {
        logic       en;
        word_addr_t addr;
    } mem_rd_t;

    //////////////////////////////
    // register map
    //////////////////////////////
    localparam word_addr_t RegCtrl      = 8'h00;
    localparam word_addr_t RegStatus    = 8'h01;
    localparam word_addr_t RegSpinInit  = 8'h02;
    localparam word_addr_t RegHLo       = 8'h03;
    localparam word_addr_t RegHHi       = 8'h04;
    localparam word_addr_t RegResSpin   = 8'h05;
    localparam word_addr_t RegResEnergy = 8'h06;

    // row r low word at 0x40+2r, high word at 0x41+2r
    localparam word_addr_t JMemBase    = 8'h40;
    // icon k at 0x60+k, low 16 bits
    localparam word_addr_t FlipMemBase = 8'h60;
    localparam word_addr_t FlipMemEnd  = 8'h70;

endpackage

// File: ising_l1_mem.sv
/*
 * local memory, host writes one word at a time,
 * core reads a whole row with one cycle latency
 */
`timescale 1ns/1ps

module ising_l1_mem #(
    parameter int Depth       = 16,
    parameter int WordsPerRow = 2
) (
    input  logic                                         clk_i,
    input  logic                                         arst_n_i,
    input  ising_bus_pkg::mem_wr_t                       wr_i,
    input  ising_bus_pkg::mem_rd_t                       rd_i,
    output logic [WordsPerRow*$bits(ising_bus_pkg::word_t)-1:0] rdata_o
);
    import ising_bus_pkg::*;

    localparam int NumWords = Depth * WordsPerRow;
    localparam int AddrW    = $clog2(NumWords);
    localparam int WordW    = $bits(word_t);

    word_t            mem_q [NumWords];
    logic [AddrW-1:0] rd_base;

    // rows are stored as consecutive words, low word first
    assign rd_base = AddrW'(rd_i.addr * WordsPerRow);

    always_ff @(posedge clk_i) begin
        if (wr_i.en && (wr_i.addr < word_addr_t'(NumWords))) begin
            mem_q[wr_i.addr[AddrW-1:0]] <= wr_i.data;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_o <= '0;
        end else if (rd_i.en) begin
            // out of range rows read as zero
            for (int w = 0; w < WordsPerRow; w++) begin
                if (rd_i.addr < word_addr_t'(Depth)) begin
                    rdata_o[w*WordW +: WordW] <= mem_q[rd_base + AddrW'(w)];
                end else begin
                    rdata_o[w*WordW +: WordW] <= '0;
                end
            end
        end
    end

endmodule

// File: ising_field_unit.sv
/*
 * local field of one spin from its weight row,
 * bias and current spins, one cycle latency
 */
`timescale 1ns/1ps

module ising_field_unit (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     row_valid_i,
    input  ising_cfg_pkg::row_idx_t  row_idx_i,
    input  ising_cfg_pkg::j_row_t    j_row_i,
    input  ising_cfg_pkg::spin_vec_t spin_i,
    input  ising_cfg_pkg::h_vec_t    h_bias_i,
    output logic                     field_valid_o,
    output ising_cfg_pkg::row_idx_t  field_idx_o,
    output ising_cfg_pkg::field_t    field_o
);
    import ising_cfg_pkg::*;

    h_val_t h_sel;
    j_val_t j_sel;
    field_t field_sum;

    // h_i + sum_j J_ij * s_j, with s_j = +-1
    always_comb begin
        h_sel     = h_bias_i[row_idx_i*BitH +: BitH];
        field_sum = field_t'(h_sel);
        for (int j = 0; j < NumSpin; j++) begin
            j_sel = j_row_i[j*BitJ +: BitJ];
            if (spin_i[j]) begin
                field_sum = field_sum + field_t'(j_sel);
            end else begin
                field_sum = field_sum - field_t'(j_sel);
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            field_valid_o <= 1'b0;
        end else begin
            field_valid_o <= row_valid_i;
        end
    end

    // index travels with the sum
    always_ff @(posedge clk_i) begin
        if (row_valid_i) begin
            field_idx_o <= row_idx_i;
            field_o     <= field_sum;
        end
    end

endmodule

// File: ising_anneal_ctrl.sv
/*
 * annealing iteration FSM: icon fetch, row reads,
 * spin update, energy accumulation and result push
 */
`timescale 1ns/1ps

module ising_anneal_ctrl (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      start_i,
    input  ising_cfg_pkg::iter_cnt_t  iter_num_i,
    input  ising_cfg_pkg::icon_cnt_t  icon_count_i,
    input  ising_cfg_pkg::spin_vec_t  spin_init_i,
    output logic                      busy_o,
    output ising_bus_pkg::mem_rd_t    j_rd_o,
    output ising_bus_pkg::mem_rd_t    flip_rd_o,
    input  ising_cfg_pkg::spin_vec_t  flip_icon_i,
    output logic                      row_valid_o,
    output ising_cfg_pkg::row_idx_t   row_idx_o,
    output ising_cfg_pkg::spin_vec_t  spin_o,
    input  logic                      field_valid_i,
    input  ising_cfg_pkg::row_idx_t   field_idx_i,
    input  ising_cfg_pkg::field_t     field_i,
    output logic                      push_o,
    output ising_cfg_pkg::result_t    push_data_o
);
    import ising_cfg_pkg::*;
    import ising_bus_pkg::*;

    ctrl_state_e state_q;
    row_idx_t    row_cnt_q;
    iter_cnt_t   iter_left_q;
    icon_cnt_t   icon_sel_q;
    icon_cnt_t   icon_num_q;
    spin_vec_t   spin_q;
    spin_vec_t   spin_next_q;
    energy_t     energy_q;
    logic        row_valid_q;
    row_idx_t    row_idx_q;

    //////////////////////////////
    // memory reads
    //////////////////////////////
    always_comb begin
        flip_rd_o.en   = (state_q == StIcon);
        flip_rd_o.addr = word_addr_t'(icon_sel_q);
        j_rd_o.en      = (state_q == StRows);
        j_rd_o.addr    = word_addr_t'(row_cnt_q);
    end

    assign busy_o      = (state_q != StIdle);
    assign row_valid_o = row_valid_q;
    assign row_idx_o   = row_idx_q;
    assign spin_o      = spin_q;

    // result leaves in the commit cycle
    assign push_o             = (state_q == StCommit);
    assign push_data_o.spin   = spin_next_q;
    assign push_data_o.energy = energy_q;

    //////////////////////////////
    // iteration FSM
    //////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= StIdle;
            row_cnt_q   <= '0;
            iter_left_q <= '0;
            icon_sel_q  <= '0;
            icon_num_q  <= '0;
            spin_q      <= '0;
            spin_next_q <= '0;
            energy_q    <= '0;
            row_valid_q <= 1'b0;
            row_idx_q   <= '0;
        end else begin
            // weight row comes back one cycle after its read
            row_valid_q <= (state_q == StRows);
            row_idx_q   <= row_cnt_q;

            // fields return during ROWS and DRAIN
            if (field_valid_i) begin
                if (flip_icon_i[field_idx_i]) begin
                    spin_next_q[field_idx_i] <= (field_i >= 0);
                end
                if (spin_q[field_idx_i]) begin
                    energy_q <= energy_q - energy_t'(field_i);
                end else begin
                    energy_q <= energy_q + energy_t'(field_i);
                end
            end

            unique case (state_q)
                StIdle: begin
                    if (start_i && (iter_num_i != '0)) begin
                        spin_q      <= spin_init_i;
                        iter_left_q <= iter_num_i;
                        icon_sel_q  <= '0;
                        // zero icons behaves as one
                        icon_num_q  <= (icon_count_i == '0) ? icon_cnt_t'(1) : icon_count_i;
                        state_q     <= StIcon;
                    end
                end
                StIcon: begin
                    spin_next_q <= spin_q;
                    energy_q    <= '0;
                    row_cnt_q   <= '0;
                    state_q     <= StRows;
                end
                StRows: begin
                    row_cnt_q <= row_cnt_q + 1'b1;
                    if (row_cnt_q == row_idx_t'(NumSpin - 1)) begin
                        state_q <= StDrain;
                    end
                end
                StDrain: begin
                    // two rows still in flight
                    row_cnt_q <= row_cnt_q + 1'b1;
                    if (row_cnt_q == row_idx_t'(1)) begin
                        state_q <= StCommit;
                    end
                end
                StCommit: begin
                    spin_q      <= spin_next_q;
                    iter_left_q <= iter_left_q - 1'b1;
                    if (icon_sel_q + 1'b1 == icon_num_q) begin
                        icon_sel_q <= '0;
                    end else begin
                        icon_sel_q <= icon_sel_q + 1'b1;
                    end
                    state_q <= (iter_left_q == iter_cnt_t'(1)) ? StIdle : StIcon;
                end
                default: state_q <= StIdle;
            endcase
        end
    end

endmodule

// File: ising_result_fifo.sv
/*
 * result FIFO, circular buffer that overwrites
 * the oldest entry when full
 */
`timescale 1ns/1ps

module ising_result_fifo #(
    parameter int Depth = 2
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         push_i,
    input  ising_cfg_pkg::result_t       push_data_i,
    input  logic                         pop_i,
    output ising_cfg_pkg::result_t       head_o,
    output logic [$clog2(Depth+1)-1:0]   count_o
);
    import ising_cfg_pkg::*;

    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;

    typedef logic [PtrW-1:0] ptr_t;

    result_t                     mem_q [Depth];
    ptr_t                        wr_ptr_q;
    ptr_t                        rd_ptr_q;
    logic [$clog2(Depth+1)-1:0]  count_q;
    logic                        do_pop;
    logic                        drop;

    function automatic ptr_t ptr_inc(ptr_t p);
        return (p == ptr_t'(Depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_pop  = pop_i && (count_q != '0);
    // full push without pop pushes out the oldest entry
    assign drop    = push_i && (count_q == Depth) && !do_pop;
    assign count_o = count_q;
    assign head_o  = (count_q == '0) ? '0 : mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_pop || drop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (push_i && !do_pop && !drop) begin
                count_q <= count_q + 1'b1;
            end else if (!push_i && do_pop) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// File: ising_reg_file.sv
/*
 * host bus decode, configuration registers,
 * memory write ports, status and result readout
 */
`timescale 1ns/1ps

module ising_reg_file (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  ising_bus_pkg::host_req_t  host_req_i,
    output ising_bus_pkg::host_rsp_t  host_rsp_o,
    output ising_bus_pkg::mem_wr_t    j_wr_o,
    output ising_bus_pkg::mem_wr_t    flip_wr_o,
    output logic                      start_o,
    output ising_cfg_pkg::iter_cnt_t  iter_num_o,
    output ising_cfg_pkg::icon_cnt_t  icon_count_o,
    output ising_cfg_pkg::spin_vec_t  spin_init_o,
    output ising_cfg_pkg::h_vec_t     h_bias_o,
    input  logic                      busy_i,
    input  ising_cfg_pkg::result_t    fifo_head_i,
    input  logic [1:0]                fifo_count_i,
    output logic                      fifo_pop_o
);
    import ising_cfg_pkg::*;
    import ising_bus_pkg::*;

    logic      wr_en;
    logic      rd_en;
    logic      start_q;
    iter_cnt_t iter_num_q;
    icon_cnt_t icon_count_q;
    spin_vec_t spin_init_q;
    word_t     h_lo_q;
    word_t     h_hi_q;
    word_t     rdata;
    host_rsp_t rsp_q;

    assign wr_en = host_req_i.valid && host_req_i.write;
    assign rd_en = host_req_i.valid && !host_req_i.write;

    //////////////////////////////
    // memory regions
    //////////////////////////////
    always_comb begin
        j_wr_o.en      = wr_en && (host_req_i.addr >= JMemBase)
                         && (host_req_i.addr < FlipMemBase);
        j_wr_o.addr    = host_req_i.addr - JMemBase;
        j_wr_o.data    = host_req_i.wdata;
        flip_wr_o.en   = wr_en && (host_req_i.addr >= FlipMemBase)
                         && (host_req_i.addr < FlipMemEnd);
        flip_wr_o.addr = host_req_i.addr - FlipMemBase;
        flip_wr_o.data = host_req_i.wdata;
    end

    //////////////////////////////
    // configuration registers
    //////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            start_q      <= 1'b0;
            iter_num_q   <= '0;
            icon_count_q <= '0;
            spin_init_q  <= '0;
            h_lo_q       <= '0;
            h_hi_q       <= '0;
        end else begin
            // start is a one-cycle strobe
            start_q <= wr_en && (host_req_i.addr == RegCtrl) && host_req_i.wdata[0];
            if (wr_en) begin
                unique case (host_req_i.addr)
                    RegCtrl: begin
                        iter_num_q   <= host_req_i.wdata[15:8];
                        icon_count_q <= host_req_i.wdata[18:16];
                    end
                    RegSpinInit: spin_init_q <= host_req_i.wdata[NumSpin-1:0];
                    RegHLo:      h_lo_q      <= host_req_i.wdata;
                    RegHHi:      h_hi_q      <= host_req_i.wdata;
                    default: ;
                endcase
            end
        end
    end

    assign start_o      = start_q;
    assign iter_num_o   = iter_num_q;
    assign icon_count_o = icon_count_q;
    assign spin_init_o  = spin_init_q;
    assign h_bias_o     = {h_hi_q, h_lo_q};

    //////////////////////////////
    // read path
    //////////////////////////////
    always_comb begin
        unique case (host_req_i.addr)
            RegCtrl:      rdata = {13'b0, icon_count_q, iter_num_q, 8'b0};
            RegStatus:    rdata = {22'b0, fifo_count_i, 7'b0, busy_i};
            RegSpinInit:  rdata = {16'b0, spin_init_q};
            RegHLo:       rdata = h_lo_q;
            RegHHi:       rdata = h_hi_q;
            RegResSpin:   rdata = {16'b0, fifo_head_i.spin};
            RegResEnergy: rdata = word_t'(fifo_head_i.energy);
            default:      rdata = '0;
        endcase
    end

    // energy read retires the head entry
    assign fifo_pop_o = rd_en && (host_req_i.addr == RegResEnergy);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_q <= '0;
        end else begin
            rsp_q.rvalid <= rd_en;
            rsp_q.rdata  <= rd_en ? rdata : '0;
        end
    end

    assign host_rsp_o = rsp_q;

endmodule

// File: ising_core_top.sv
/*
 * Ising annealing core top level, register block,
 * weight and icon memories, compute blocks
 */
`timescale 1ns/1ps

module ising_core_top #(
    parameter int FlipIconDepth = 4,
    parameter int ResultDepth   = 2
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  ising_bus_pkg::host_req_t  host_req_i,
    output ising_bus_pkg::host_rsp_t  host_rsp_o
);
    import ising_cfg_pkg::*;
    import ising_bus_pkg::*;

    mem_wr_t   j_wr;
    mem_wr_t   flip_wr;
    mem_rd_t   j_rd;
    mem_rd_t   flip_rd;
    j_row_t    j_row;
    word_t     flip_row;
    logic      start;
    iter_cnt_t iter_num;
    icon_cnt_t icon_count;
    spin_vec_t spin_init;
    h_vec_t    h_bias;
    logic      busy;
    logic      row_valid;
    row_idx_t  row_idx;
    spin_vec_t spin;
    logic      field_valid;
    row_idx_t  field_idx;
    field_t    field;
    logic      push;
    result_t   push_data;
    result_t   fifo_head;
    logic [$clog2(ResultDepth+1)-1:0] fifo_count;
    logic      fifo_pop;

    ising_reg_file u_reg_file (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .host_req_i   (host_req_i),
        .host_rsp_o   (host_rsp_o),
        .j_wr_o       (j_wr),
        .flip_wr_o    (flip_wr),
        .start_o      (start),
        .iter_num_o   (iter_num),
        .icon_count_o (icon_count),
        .spin_init_o  (spin_init),
        .h_bias_o     (h_bias),
        .busy_i       (busy),
        .fifo_head_i  (fifo_head),
        .fifo_count_i (fifo_count),
        .fifo_pop_o   (fifo_pop)
    );

    //////////////////////////////
    // local memories
    //////////////////////////////
    ising_l1_mem #(
        .Depth       (NumSpin),
        .WordsPerRow (2)
    ) u_j_mem (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .wr_i     (j_wr),
        .rd_i     (j_rd),
        .rdata_o  (j_row)
    );

    ising_l1_mem #(
        .Depth       (FlipIconDepth),
        .WordsPerRow (1)
    ) u_flip_mem (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .wr_i     (flip_wr),
        .rd_i     (flip_rd),
        .rdata_o  (flip_row)
    );

    //////////////////////////////
    // compute
    //////////////////////////////
    ising_anneal_ctrl u_anneal_ctrl (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .start_i       (start),
        .iter_num_i    (iter_num),
        .icon_count_i  (icon_count),
        .spin_init_i   (spin_init),
        .busy_o        (busy),
        .j_rd_o        (j_rd),
        .flip_rd_o     (flip_rd),
        .flip_icon_i   (flip_row[NumSpin-1:0]),
        .row_valid_o   (row_valid),
        .row_idx_o     (row_idx),
        .spin_o        (spin),
        .field_valid_i (field_valid),
        .field_idx_i   (field_idx),
        .field_i       (field),
        .push_o        (push),
        .push_data_o   (push_data)
    );

    ising_field_unit u_field_unit (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .row_valid_i   (row_valid),
        .row_idx_i     (row_idx),
        .j_row_i       (j_row),
        .spin_i        (spin),
        .h_bias_i      (h_bias),
        .field_valid_o (field_valid),
        .field_idx_o   (field_idx),
        .field_o       (field)
    );

    ising_result_fifo #(
        .Depth (ResultDepth)
    ) u_result_fifo (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (fifo_pop),
        .head_o      (fifo_head),
        .count_o     (fifo_count)
    );

endmodule

// File: tb_ising_core.sv
/*
 * testbench for the Ising annealing core: host bus tasks,
 * reference model of fields, flips and energy, five tests
 */
`timescale 1ns/1ps

module tb_ising_core;
    import ising_cfg_pkg::*;
    import ising_bus_pkg::*;

    localparam int NumTests   = 5;
    localparam int NumIters   = 8;
    localparam int IterCycles = 20;
    localparam int BusCycles  = 64;
    // about ten times the expected run length
    localparam int TimeoutCycles = 10 * (NumIters * IterCycles + NumTests * BusCycles);

    logic      clk;
    logic      arst_n;
    host_req_t host_req;
    host_rsp_t host_rsp;

    logic [3:0] j_nib [NumSpin][NumSpin];
    logic [3:0] h_nib [NumSpin];
    int         cycle_cnt;
    int         errors;
    int         checks;
    int         tests_failed;
    int         test_err_base;
    word_t      wr_word;
    word_t      rd_word;
    spin_vec_t  spin_start;
    spin_vec_t  model_spin;
    spin_vec_t  icons [2];
    spin_vec_t  exp_spin [3];
    int         exp_energy [3];

    ising_core_top #(
        .FlipIconDepth (4),
        .ResultDepth   (2)
    ) u_ising_core_top (
        .clk_i      (clk),
        .arst_n_i   (arst_n),
        .host_req_i (host_req),
        .host_rsp_o (host_rsp)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TimeoutCycles) begin
            $display("timeout: the DUT did not finish within %0d cycles", TimeoutCycles);
            $display("Verification failed");
            $finish;
        end
    end

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic int nib_value(input logic [3:0] v);
        return v[3] ? int'(v) - 16 : int'(v);
    endfunction

    // h_i plus sum of J_ij times +-1
    function automatic int local_field(input int i, input spin_vec_t s);
        int f;
        f = nib_value(h_nib[i]);
        for (int j = 0; j < NumSpin; j++) begin
            f = s[j] ? f + nib_value(j_nib[i][j]) : f - nib_value(j_nib[i][j]);
        end
        return f;
    endfunction

    task automatic model_step(input spin_vec_t icon, inout spin_vec_t s, output int energy);
        spin_vec_t s_new;
        int        f;
        s_new  = s;
        energy = 0;
        for (int i = 0; i < NumSpin; i++) begin
            f = local_field(i, s);
            if (icon[i]) begin
                s_new[i] = (f >= 0);
            end
            // energy is taken over the old spins
            energy = s[i] ? energy - f : energy + f;
        end
        s = s_new;
    endtask

    //////////////////////////////
    // host bus
    //////////////////////////////
    task automatic check_value(input string what, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic bus_write(input word_addr_t addr, input word_t data);
        host_req.valid = 1'b1;
        host_req.write = 1'b1;
        host_req.addr  = addr;
        host_req.wdata = data;
        @(negedge clk);
        host_req.valid = 1'b0;
    endtask

    task automatic bus_read(input word_addr_t addr, output word_t data);
        host_req.valid = 1'b1;
        host_req.write = 1'b0;
        host_req.addr  = addr;
        @(negedge clk);
        host_req.valid = 1'b0;
        checks++;
        assert (host_rsp.rvalid === 1'b1) else begin
            $display("read of address %h at %0t got no response", addr, $time);
            errors++;
        end
        data = host_rsp.rdata;
    endtask

    task automatic load_weights();
        word_t lo;
        word_t hi;
        for (int r = 0; r < NumSpin; r++) begin
            for (int j = 0; j < NumSpin; j++) begin
                j_nib[r][j] = 4'($urandom);
            end
            for (int j = 0; j < 8; j++) begin
                lo[4*j +: 4] = j_nib[r][j];
                hi[4*j +: 4] = j_nib[r][j+8];
            end
            bus_write(JMemBase + word_addr_t'(2*r), lo);
            bus_write(JMemBase + word_addr_t'(2*r + 1), hi);
        end
    endtask

    task automatic load_biases();
        word_t lo;
        word_t hi;
        for (int i = 0; i < NumSpin; i++) begin
            h_nib[i] = 4'($urandom);
        end
        for (int i = 0; i < 8; i++) begin
            lo[4*i +: 4] = h_nib[i];
            hi[4*i +: 4] = h_nib[i+8];
        end
        bus_write(RegHLo, lo);
        bus_write(RegHHi, hi);
    endtask

    function automatic word_t ctrl_word(input iter_cnt_t iters, input icon_cnt_t icon_cnt);
        return {13'b0, icon_cnt, iters, 7'b0, 1'b1};
    endfunction

    // busy in bit 0, FIFO count from bit 8
    task automatic check_status(input logic busy, input int count);
        word_t st;
        bus_read(RegStatus, st);
        check_value("status", st, (word_t'(count) << 8) | word_t'(busy));
    endtask

    task automatic wait_busy(input logic level);
        word_t st;
        do begin
            bus_read(RegStatus, st);
        end while (st[0] !== level);
    endtask

    task automatic run_command(input iter_cnt_t iters, input icon_cnt_t icon_cnt);
        bus_write(RegCtrl, ctrl_word(iters, icon_cnt));
        wait_busy(1'b1);
        wait_busy(1'b0);
    endtask

    // spin read first, energy read pops the head
    task automatic check_result(input string what, input spin_vec_t spin, input int energy);
        word_t got;
        bus_read(RegResSpin, got);
        check_value({what, " spin"}, got, {16'b0, spin});
        bus_read(RegResEnergy, got);
        check_value({what, " energy"}, got, word_t'(energy));
    endtask

    task automatic finish_test(input string name);
        if (errors == test_err_base) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_err_base);
            tests_failed++;
        end
        test_err_base = errors;
    endtask

    task automatic new_spins();
        spin_start = 16'($urandom);
        bus_write(RegSpinInit, {16'b0, spin_start});
        model_spin = spin_start;
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////
    initial begin
        clk           = 1'b0;
        arst_n        = 1'b0;
        host_req      = '0;
        cycle_cnt     = 0;
        errors        = 0;
        checks        = 0;
        tests_failed  = 0;
        test_err_base = 0;
        void'($urandom(32'he8bf_f523));
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // reset values and register readback
        check_status(1'b0, 0);
        wr_word = $urandom;
        bus_write(RegSpinInit, wr_word);
        bus_read(RegSpinInit, rd_word);
        check_value("spin init", rd_word, {16'b0, wr_word[15:0]});
        wr_word = $urandom;
        bus_write(RegHLo, wr_word);
        bus_read(RegHLo, rd_word);
        check_value("h low", rd_word, wr_word);
        wr_word = $urandom;
        bus_write(RegHHi, wr_word);
        bus_read(RegHHi, rd_word);
        check_value("h high", rd_word, wr_word);
        finish_test("reset and registers");

        // one iteration, every spin may flip
        load_weights();
        load_biases();
        new_spins();
        bus_write(FlipMemBase, 32'h0000_ffff);
        model_step(16'hffff, model_spin, exp_energy[0]);
        run_command(8'd1, 3'd1);
        check_status(1'b0, 1);
        check_result("single iteration", model_spin, exp_energy[0]);
        check_status(1'b0, 0);
        finish_test("single iteration");

        // masked icons used in turn, icon 2 must stay unused
        load_biases();
        new_spins();
        icons[0] = 16'($urandom) & 16'h0ff0;
        icons[1] = 16'($urandom) & 16'hf00f;
        bus_write(FlipMemBase, {16'b0, icons[0]});
        bus_write(FlipMemBase + 8'd1, {16'b0, icons[1]});
        bus_write(FlipMemBase + 8'd2, 32'h0000_ffff);
        for (int k = 0; k < 3; k++) begin
            model_step(icons[k % 2], model_spin, exp_energy[k]);
            exp_spin[k] = model_spin;
        end
        run_command(8'd3, 3'd2);
        check_status(1'b0, 2);
        check_result("masked iteration 2", exp_spin[1], exp_energy[1]);
        check_result("masked iteration 3", exp_spin[2], exp_energy[2]);
        check_status(1'b0, 0);
        finish_test("flip icons");

        // three results into two entries, icon count 0 acts as 1
        load_weights();
        load_biases();
        new_spins();
        icons[0] = 16'($urandom);
        bus_write(FlipMemBase, {16'b0, icons[0]});
        for (int k = 0; k < 3; k++) begin
            model_step(icons[0], model_spin, exp_energy[k]);
            exp_spin[k] = model_spin;
        end
        run_command(8'd3, 3'd0);
        check_status(1'b0, 2);
        check_result("overflow iteration 2", exp_spin[1], exp_energy[1]);
        check_result("overflow iteration 3", exp_spin[2], exp_energy[2]);
        check_status(1'b0, 0);
        finish_test("fifo overflow");

        // second start lands while the first run is busy
        load_biases();
        new_spins();
        icons[0] = 16'($urandom);
        bus_write(FlipMemBase, {16'b0, icons[0]});
        model_step(icons[0], model_spin, exp_energy[0]);
        bus_write(RegCtrl, ctrl_word(8'd1, 3'd1));
        wait_busy(1'b1);
        bus_write(RegCtrl, ctrl_word(8'd4, 3'd2));
        wait_busy(1'b0);
        check_status(1'b0, 1);
        check_result("start while busy", model_spin, exp_energy[0]);
        check_status(1'b0, 0);
        finish_test("start while busy");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 NumTests, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: tb.f
ising_cfg_pkg.sv
ising_bus_pkg.sv
ising_l1_mem.sv
ising_field_unit.sv
ising_anneal_ctrl.sv
ising_result_fifo.sv
ising_reg_file.sv
ising_core_top.sv
tb_ising_core.sv

// File: Makefile
TOP := tb_ising_core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) | awk '{ print } /^Verification passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
